// ==== source/wb_pkg.sv ====
// Writeback constants, lane and register types, pipe and opcode enums, request and result structs
package wb_pkg;

	// Lane and register geometry
	localparam int NUM_LANES     = 4;
	localparam int REG_BITS      = 32;
	localparam int BYTES_PER_REG = 4;
	localparam int NUM_PIPES     = 4;
	localparam int NUM_THREADS   = 4;
	localparam int REG_ADDR_BITS = 6;

	// Bits 3..2 pick the lane, bits 1..0 the byte within the word
	localparam int OFFSET_BITS = 4;

	// Lane 0 sits in the least significant word
	typedef logic [NUM_LANES-1:0][REG_BITS-1:0] lane_data_t;
	typedef logic [NUM_LANES-1:0]               lane_mask_t;
	typedef logic [BYTES_PER_REG-1:0]           byte_en_t;
	typedef logic [$clog2(NUM_THREADS)-1:0]     thread_id_t;
	typedef logic [REG_ADDR_BITS-1:0]           reg_addr_t;

	// Doubles as the FIFO index
	typedef enum logic [1:0] {
		PIPE_FP  = 2'd0,
		PIPE_INT = 2'd1,
		PIPE_SPM = 2'd2,
		PIPE_MEM = 2'd3
	} pipe_id_t;

	typedef enum logic [4:0] {
		OP_OTHER,
		OP_MOVEI,
		OP_MOVEI_L,
		OP_MOVEI_H,
		LOAD_8,
		LOAD_16,
		LOAD_32,
		LOAD_8_U,
		LOAD_16_U,
		LOAD_32_U,
		LOAD_V_8,
		LOAD_V_16,
		LOAD_V_32,
		LOAD_V_8_U,
		LOAD_V_16_U,
		LOAD_V_32_U
	} opcode_t;

	// What one execution pipe hands to writeback
	typedef struct packed {
		thread_id_t             thread_id;
		reg_addr_t              destination;
		logic                   has_destination;
		logic                   is_vectorial;
		opcode_t                op_code;
		lane_mask_t             lane_mask;
		lane_data_t             data;
		logic [OFFSET_BITS-1:0] offset;
	} ex_result_t;

	// Write request toward the register files
	typedef struct packed {
		thread_id_t thread_id;
		reg_addr_t  register;
		logic       is_scalar;
		lane_mask_t lane_mask;
		byte_en_t   byte_enable;
		lane_data_t data;
	} wb_result_t;

endpackage

// ==== source/wb_request_fifo.sv ====
// Per-pipe request FIFO with almost-full credit flag and overflow/underflow assertions
`timescale 1ns/1ps

module wb_request_fifo #(
	parameter int FIFO_DEPTH   = 2 * wb_pkg::NUM_THREADS,
	parameter int FIFO_RESERVE = wb_pkg::NUM_THREADS
) (
	input  logic               clk,
	input  logic               reset,
	input  logic               enq,
	input  wb_pkg::ex_result_t enq_data,
	input  logic               deq,
	output wb_pkg::ex_result_t head,
	output logic               empty,
	output logic               almost_full
);

	localparam int PTR_BITS   = (FIFO_DEPTH > 1) ? $clog2(FIFO_DEPTH) : 1;
	localparam int COUNT_BITS = $clog2(FIFO_DEPTH + 1);

	wb_pkg::ex_result_t    mem [FIFO_DEPTH];
	logic [PTR_BITS-1:0]   rd_ptr;
	logic [PTR_BITS-1:0]   wr_ptr;
	logic [COUNT_BITS-1:0] count;
	logic                  full;

	assign empty = (count == '0);
	assign full  = (count == COUNT_BITS'(FIFO_DEPTH));
	assign head  = mem[rd_ptr];

	// Raised early so results already in flight still fit
	assign almost_full = (count >= COUNT_BITS'(FIFO_DEPTH - FIFO_RESERVE));

	always_ff @(posedge clk) begin
		if (enq) begin
			mem[wr_ptr] <= enq_data;
		end
	end

	always_ff @(posedge clk or posedge reset) begin
		if (reset) begin
			rd_ptr <= '0;
			wr_ptr <= '0;
			count  <= '0;
		end else begin
			if (enq) begin
				wr_ptr <= (wr_ptr == PTR_BITS'(FIFO_DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
			end
			if (deq) begin
				rd_ptr <= (rd_ptr == PTR_BITS'(FIFO_DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
			end
			case ({enq, deq})
				2'b10:   count <= count + 1'b1;
				2'b01:   count <= count - 1'b1;
				default: count <= count;
			endcase
		end
	end

	// The issuer ran past its credit
	overflow_check: assert property (@(posedge clk) disable iff (reset) !(enq && full && !deq))
		else $error("request FIFO overflow");

	underflow_check: assert property (@(posedge clk) disable iff (reset) !(deq && empty))
		else $error("request FIFO dequeued while empty");

endmodule

// ==== source/wb_rr_arbiter.sv ====
// Round-robin arbiter over the pipe FIFOs with a rotating priority pointer and grant checks
`timescale 1ns/1ps

module wb_rr_arbiter (
	input  logic                         clk,
	input  logic                         reset,
	input  logic [wb_pkg::NUM_PIPES-1:0] requests,
	output logic [wb_pkg::NUM_PIPES-1:0] grant
);

	localparam int IDX_BITS = $clog2(wb_pkg::NUM_PIPES);

	logic [IDX_BITS-1:0] ptr;
	logic [IDX_BITS-1:0] next_ptr;

	// Search starts at the pointer and wraps around
	always_comb begin
		int   idx;
		logic found;
		grant    = '0;
		next_ptr = ptr;
		found    = 1'b0;
		for (int off = 0; off < wb_pkg::NUM_PIPES; off++) begin
			idx = (int'(ptr) + off) % wb_pkg::NUM_PIPES;
			if (!found && requests[idx]) begin
				grant[idx] = 1'b1;
				found      = 1'b1;
				next_ptr   = IDX_BITS'((idx + 1) % wb_pkg::NUM_PIPES);
			end
		end
	end

	// Winner drops to lowest priority
	always_ff @(posedge clk or posedge reset) begin
		if (reset) begin
			ptr <= IDX_BITS'(wb_pkg::PIPE_FP);
		end else if (|grant) begin
			ptr <= next_ptr;
		end
	end

	grant_onehot: assert property (@(posedge clk) disable iff (reset) $onehot0(grant))
		else $error("arbiter granted more than one pipe");

	grant_requested: assert property (@(posedge clk) disable iff (reset)
		(grant & ~requests) == '0)
		else $error("arbiter granted a pipe with no pending request");

endmodule

// ==== source/load_result_composer.sv ====
// Load data alignment with byte/half/word selection and zero or sign extension per lane
`timescale 1ns/1ps

module load_result_composer (
	input  wb_pkg::opcode_t                op_code,
	input  logic [wb_pkg::OFFSET_BITS-1:0] offset,
	input  wb_pkg::lane_data_t             raw,
	output wb_pkg::lane_data_t             data
);

	localparam int W = wb_pkg::REG_BITS;

	wb_pkg::lane_data_t byte_u;
	wb_pkg::lane_data_t byte_s;
	wb_pkg::lane_data_t half_u;
	wb_pkg::lane_data_t half_s;
	logic [1:0]         lane_sel;

	// Scalar loads take their word from this lane
	assign lane_sel = offset[3:2];

	for (genvar l = 0; l < wb_pkg::NUM_LANES; l++) begin : g_lane
		logic [7:0]  byte_val;
		logic [15:0] half_val;

		// Byte picked by offset[1:0], half by offset[1]
		assign byte_val = raw[l][8 * offset[1:0] +: 8];
		assign half_val = raw[l][16 * offset[1] +: 16];

		assign byte_u[l] = {{(W - 8){1'b0}}, byte_val};
		assign byte_s[l] = {{(W - 8){byte_val[7]}}, byte_val};
		assign half_u[l] = {{(W - 16){1'b0}}, half_val};
		assign half_s[l] = {{(W - 16){half_val[15]}}, half_val};
	end

	always_comb begin
		data = '0;
		case (op_code)
			// Scalar loads land in lane 0, the rest stay zero
			wb_pkg::LOAD_8:    data[0] = byte_s[lane_sel];
			wb_pkg::LOAD_16:   data[0] = half_s[lane_sel];
			wb_pkg::LOAD_8_U:  data[0] = byte_u[lane_sel];
			wb_pkg::LOAD_16_U: data[0] = half_u[lane_sel];
			wb_pkg::LOAD_32,
			wb_pkg::LOAD_32_U: data[0] = raw[lane_sel];

			// Vector loads extend every lane in place
			wb_pkg::LOAD_V_8:    data = byte_s;
			wb_pkg::LOAD_V_16:   data = half_s;
			wb_pkg::LOAD_V_8_U:  data = byte_u;
			wb_pkg::LOAD_V_16_U: data = half_u;
			wb_pkg::LOAD_V_32,
			wb_pkg::LOAD_V_32_U: data = raw;

			default: data = '0;
		endcase
	end

endmodule

// ==== source/writeback_stage.sv ====
// Writeback top level with pipe FIFOs, round-robin select, load composition and output register
`timescale 1ns/1ps

module writeback_stage #(
	parameter int FIFO_DEPTH   = 2 * wb_pkg::NUM_THREADS,
	parameter int FIFO_RESERVE = wb_pkg::NUM_THREADS
) (
	input  logic                         clk,
	input  logic                         reset,
	input  logic [wb_pkg::NUM_PIPES-1:0] ex_valid,
	input  wb_pkg::ex_result_t           ex_results [wb_pkg::NUM_PIPES],
	output logic                         wb_valid,
	output wb_pkg::wb_result_t           wb_out,
	output logic [wb_pkg::NUM_PIPES-1:0] full_flags
);

	localparam int IDX_BITS = $clog2(wb_pkg::NUM_PIPES);

	wb_pkg::ex_result_t           heads [wb_pkg::NUM_PIPES];
	logic [wb_pkg::NUM_PIPES-1:0] empty;
	logic [wb_pkg::NUM_PIPES-1:0] grant;
	logic [IDX_BITS-1:0]          sel_idx;
	wb_pkg::ex_result_t           sel;
	wb_pkg::lane_data_t           composed;
	logic                         load_pipe;
	wb_pkg::byte_en_t             byte_en;
	wb_pkg::wb_result_t           wb_next;
	logic                         write_reg;

	// One FIFO per pipe
	// The granted head leaves at the edge that registers it
	for (genvar p = 0; p < wb_pkg::NUM_PIPES; p++) begin : g_fifo
		wb_request_fifo #(
			.FIFO_DEPTH  (FIFO_DEPTH),
			.FIFO_RESERVE(FIFO_RESERVE)
		) u_fifo (
			.clk        (clk),
			.reset      (reset),
			.enq        (ex_valid[p]),
			.enq_data   (ex_results[p]),
			.deq        (grant[p]),
			.head       (heads[p]),
			.empty      (empty[p]),
			.almost_full(full_flags[p])
		);
	end

	wb_rr_arbiter u_arbiter (
		.clk     (clk),
		.reset   (reset),
		.requests(~empty),
		.grant   (grant)
	);

	// One-hot grant to FIFO index
	always_comb begin
		sel_idx = '0;
		for (int p = 0; p < wb_pkg::NUM_PIPES; p++) begin
			if (grant[p]) begin
				sel_idx = IDX_BITS'(p);
			end
		end
	end

	assign sel = heads[sel_idx];

	load_result_composer u_composer (
		.op_code(sel.op_code),
		.offset (sel.offset),
		.raw    (sel.data),
		.data   (composed)
	);

	// Only the memory pipes return load data that needs aligning
	assign load_pipe = (sel_idx == wb_pkg::PIPE_SPM) || (sel_idx == wb_pkg::PIPE_MEM);

	// Partial register write for the move-immediate halves
	always_comb begin
		case (sel.op_code)
			wb_pkg::OP_MOVEI:   byte_en = 4'b1111;
			wb_pkg::OP_MOVEI_L: byte_en = 4'b0011;
			wb_pkg::OP_MOVEI_H: byte_en = 4'b1100;
			default:            byte_en = '1;
		endcase
	end

	always_comb begin
		wb_next.thread_id   = sel.thread_id;
		wb_next.register    = sel.destination;
		wb_next.is_scalar   = ~sel.is_vectorial;
		wb_next.lane_mask   = sel.lane_mask;
		wb_next.byte_enable = byte_en;
		wb_next.data        = load_pipe ? composed : sel.data;
	end

	// Requests with no destination are drained silently
	assign write_reg = (|grant) && sel.has_destination;

	always_ff @(posedge clk or posedge reset) begin
		if (reset) begin
			wb_valid <= 1'b0;
		end else begin
			wb_valid <= write_reg;
		end
	end

	always_ff @(posedge clk) begin
		if (write_reg) begin
			wb_out <= wb_next;
		end
	end

endmodule

// ==== tests/clock_gen.sv ====
// Testbench clock source and power-on reset generator
`timescale 1ns/1ps

module clock_gen #(
	parameter int PERIOD       = 4,
	parameter int RESET_CYCLES = 4
) (
	output logic clk,
	output logic reset
);

	initial begin
		clk = 1'b0;
		forever #(PERIOD / 2) clk = ~clk;
	end

	// Reset released on a rising edge
	initial begin
		reset = 1'b1;
		repeat (RESET_CYCLES) @(posedge clk);
		reset <= 1'b0;
	end

endmodule

// ==== tests/writeback_tb.sv ====
// Writeback stage testbench with stimulus, reference model, compare process and watchdog
`timescale 1ns/1ps

module writeback_tb;

	localparam int FIFO_DEPTH   = 8;
	localparam int FIFO_RESERVE = 4;
	localparam int NP           = wb_pkg::NUM_PIPES;
	localparam int LOAD_ROUNDS  = 2;
	localparam int NUM_LOAD_OPS = 12;
	localparam int SKIP_LEN     = 8;
	localparam int BURST_LEN    = 24;
	localparam int NUM_TXN = 1 + LOAD_ROUNDS * NUM_LOAD_OPS * NP + 4 * NP + SKIP_LEN * NP
		+ BURST_LEN * NP;

	logic               clk;
	logic               reset;
	logic [NP-1:0]      ex_valid;
	wb_pkg::ex_result_t ex_results [NP];
	logic               wb_valid;
	wb_pkg::wb_result_t wb_out;
	logic [NP-1:0]      full_flags;

	integer             seed = 32'hfaef;
	int                 errors = 0;
	int                 checks = 0;
	wb_pkg::wb_result_t exp_q [NP][$];
	wb_pkg::ex_result_t stage [NP];
	logic [NP-1:0]      want;

	// Occupancy model and round-robin tracking for the burst phase
	logic               track_occ = 1'b0;
	logic               rr_expect = 1'b0;
	logic               have_last = 1'b0;
	int                 last_pipe = 0;
	int                 occ [NP];
	logic [NP-1:0]      flag_seen = '0;

	clock_gen #(.PERIOD(4), .RESET_CYCLES(4)) u_clock (.clk(clk), .reset(reset));

	writeback_stage #(
		.FIFO_DEPTH  (FIFO_DEPTH),
		.FIFO_RESERVE(FIFO_RESERVE)
	) uut (
		.clk       (clk),
		.reset     (reset),
		.ex_valid  (ex_valid),
		.ex_results(ex_results),
		.wb_valid  (wb_valid),
		.wb_out    (wb_out),
		.full_flags(full_flags)
	);

	task automatic check_value(input string name, input logic [127:0] got,
			input logic [127:0] exp);
		checks++;
		if (got !== exp) begin
			errors++;
			$display("CHECK FAILED %s: got %0h expected %0h", name, got, exp);
		end
	endtask

	// Expected register-file write for one issued result
	function automatic wb_pkg::wb_result_t expected_result(input wb_pkg::ex_result_t r,
			input int pipe);
		wb_pkg::wb_result_t e;
		logic [31:0]        w;
		logic [31:0]        mask;
		int                 nbits;
		logic               sgn;
		logic               scalar;
		e.thread_id = r.thread_id;
		e.register  = r.destination;
		e.is_scalar = ~r.is_vectorial;
		e.lane_mask = r.lane_mask;
		case (r.op_code)
			wb_pkg::OP_MOVEI_L: e.byte_enable = 4'b0011;
			wb_pkg::OP_MOVEI_H: e.byte_enable = 4'b1100;
			default:            e.byte_enable = 4'b1111;
		endcase
		e.data = r.data;
		if (pipe == int'(wb_pkg::PIPE_SPM) || pipe == int'(wb_pkg::PIPE_MEM)) begin
			e.data = '0;
			case (r.op_code)
				wb_pkg::LOAD_8, wb_pkg::LOAD_8_U, wb_pkg::LOAD_V_8, wb_pkg::LOAD_V_8_U:
					nbits = 8;
				wb_pkg::LOAD_16, wb_pkg::LOAD_16_U, wb_pkg::LOAD_V_16, wb_pkg::LOAD_V_16_U:
					nbits = 16;
				wb_pkg::LOAD_32, wb_pkg::LOAD_32_U, wb_pkg::LOAD_V_32, wb_pkg::LOAD_V_32_U:
					nbits = 32;
				default:
					nbits = 0;
			endcase
			sgn = r.op_code inside {wb_pkg::LOAD_8, wb_pkg::LOAD_16, wb_pkg::LOAD_V_8,
				wb_pkg::LOAD_V_16};
			scalar = r.op_code inside {wb_pkg::LOAD_8, wb_pkg::LOAD_16, wb_pkg::LOAD_32,
				wb_pkg::LOAD_8_U, wb_pkg::LOAD_16_U, wb_pkg::LOAD_32_U};
			mask = (nbits == 32) ? 32'hffff_ffff : ((32'h1 << nbits) - 32'h1);
			for (int l = 0; l < wb_pkg::NUM_LANES && nbits != 0; l++) begin
				if (!scalar || l == 0) begin
					// Scalar loads read the lane picked by offset bits 3..2
					w = scalar ? r.data[r.offset[3:2]] : r.data[l];
					if (nbits == 8) begin
						w = w >> (int'(r.offset[1:0]) * 8);
					end else if (nbits == 16) begin
						w = w >> (int'(r.offset[1]) * 16);
					end
					w = w & mask;
					if (sgn && w[nbits-1]) begin
						w = w | ~mask;
					end
					e.data[l] = w;
				end
			end
		end
		return e;
	endfunction

	// Random result tagged with its pipe in destination bits 5..4
	function automatic wb_pkg::ex_result_t make_result(input int pipe,
			input wb_pkg::opcode_t op, input logic has_dest, input int seq);
		wb_pkg::ex_result_t r;
		logic [31:0]        rnd;
		rnd = $random(seed);
		r.thread_id       = rnd[1:0];
		r.lane_mask       = rnd[7:4];
		r.offset          = rnd[11:8];
		r.destination     = {2'(pipe), 4'(seq)};
		r.has_destination = has_dest;
		r.op_code         = op;
		if (op inside {[wb_pkg::LOAD_V_8:wb_pkg::LOAD_V_32_U]}) begin
			r.is_vectorial = 1'b1;
		end else if (op inside {[wb_pkg::LOAD_8:wb_pkg::LOAD_32_U]}) begin
			r.is_vectorial = 1'b0;
		end else begin
			r.is_vectorial = rnd[12];
		end
		for (int l = 0; l < wb_pkg::NUM_LANES; l++) begin
			r.data[l] = $random(seed);
		end
		return r;
	endfunction

	// Issue on one rising edge while holding back pipes whose full flag is up
	task automatic issue(output logic [NP-1:0] taken);
		@(posedge clk);
		taken = want & ~full_flags;
		for (int p = 0; p < NP; p++) begin
			ex_results[p] <= stage[p];
			if (taken[p] && stage[p].has_destination) begin
				exp_q[p].push_back(expected_result(stage[p], p));
			end
		end
		ex_valid <= taken;
	endtask

	task automatic issue_all();
		logic [NP-1:0] taken;
		while (want != '0) begin
			issue(taken);
			want = want & ~taken;
		end
	endtask

	task automatic idle(input int cycles);
		repeat (cycles) begin
			@(posedge clk);
			ex_valid <= '0;
		end
	endtask

	task automatic drain();
		idle(1);
		while (exp_q[0].size() + exp_q[1].size() + exp_q[2].size() + exp_q[3].size() != 0) begin
			@(posedge clk);
		end
		idle(2);
	endtask

	task automatic finish_run();
		$display("Checks: %0d  errors: %0d", checks, errors);
		if (errors == 0) begin
			$display("TESTS PASSED");
		end else begin
			$display("TESTS FAILED");
		end
		$finish;
	endtask

	// Each writeback is matched against the oldest expected result of its pipe
	always @(posedge clk) begin
		int                 pipe;
		logic               all_busy;
		wb_pkg::wb_result_t exp_r;
		pipe = -1;
		if (!reset) begin
			if (wb_valid) begin
				pipe = int'(wb_out.register[5:4]);
				if (rr_expect && have_last) begin
					check_value("wb_out.register[5:4]", 128'(pipe), 128'((last_pipe + 1) % NP));
				end
				last_pipe = pipe;
				have_last = 1'b1;
				if (exp_q[pipe].size() == 0) begin
					errors++;
					$display("Unexpected writeback from pipe %0d with nothing outstanding", pipe);
				end else begin
					exp_r = exp_q[pipe].pop_front();
					check_value("wb_out.thread_id", 128'(wb_out.thread_id), 128'(exp_r.thread_id));
					check_value("wb_out.register", 128'(wb_out.register), 128'(exp_r.register));
					check_value("wb_out.is_scalar", 128'(wb_out.is_scalar), 128'(exp_r.is_scalar));
					check_value("wb_out.lane_mask", 128'(wb_out.lane_mask), 128'(exp_r.lane_mask));
					check_value("wb_out.byte_enable", 128'(wb_out.byte_enable),
						128'(exp_r.byte_enable));
					check_value("wb_out.data", 128'(wb_out.data), 128'(exp_r.data));
				end
			end else if (rr_expect) begin
				errors++;
				$display("No writeback although all four FIFOs held requests");
			end
			if (track_occ) begin
				all_busy = 1'b1;
				for (int p = 0; p < NP; p++) begin
					if (p == pipe) begin
						occ[p]--;
					end
					check_value($sformatf("full_flags[%0d]", p), 128'(full_flags[p]),
						128'(occ[p] >= FIFO_DEPTH - FIFO_RESERVE));
					if (full_flags[p]) begin
						flag_seen[p] = 1'b1;
					end
					if (occ[p] == 0) begin
						all_busy = 1'b0;
					end
					occ[p] += int'(ex_valid[p]);
				end
				rr_expect = all_busy;
			end else begin
				foreach (occ[p]) occ[p] = 0;
				rr_expect = 1'b0;
				have_last = 1'b0;
			end
		end
	end

	initial begin
		repeat (NUM_TXN * 20 + 200) @(posedge clk);
		errors++;
		$display("Watchdog expired before all tests completed, the DUT appears to hang");
		finish_run();
	end

	initial begin
		logic [NP-1:0]   taken;
		logic [31:0]     rnd;
		wb_pkg::opcode_t op;
		int              sent [NP];
		ex_valid = '0;
		want     = '0;
		for (int p = 0; p < NP; p++) begin
			ex_results[p] = '0;
			stage[p]      = '0;
		end
		wait (reset === 1'b1);
		wait (reset === 1'b0);
		@(posedge clk);
		check_value("wb_valid", 128'(wb_valid), 128'(0));
		check_value("full_flags", 128'(full_flags), 128'(0));

		// Lone integer result enqueued one edge after issue
		stage[1] = make_result(1, wb_pkg::OP_OTHER, 1'b1, 0);
		want = 4'b0010;
		issue_all();
		idle(1);
		@(posedge clk);
		check_value("wb_valid", 128'(wb_valid), 128'(0));
		@(posedge clk);
		check_value("wb_valid", 128'(wb_valid), 128'(1));
		@(posedge clk);
		check_value("wb_valid", 128'(wb_valid), 128'(0));
		drain();

		// Every load opcode on all pipes where FP and INT pass data through
		for (int round = 0; round < LOAD_ROUNDS; round++) begin
			for (int k = 4; k < 4 + NUM_LOAD_OPS; k++) begin
				op = wb_pkg::opcode_t'(5'(k));
				for (int p = 0; p < NP; p++) begin
					stage[p] = make_result(p, op, 1'b1, k);
				end
				want = 4'b1111;
				issue_all();
			end
		end
		drain();

		// Move-immediate byte enables
		for (int k = 0; k < 4; k++) begin
			for (int p = 0; p < NP; p++) begin
				stage[p] = make_result(p, wb_pkg::opcode_t'(5'(k)), 1'b1, k);
			end
			want = 4'b1111;
			issue_all();
		end
		drain();

		// Results without destination interleaved with ones that have one
		for (int k = 0; k < SKIP_LEN; k++) begin
			for (int p = 0; p < NP; p++) begin
				stage[p] = make_result(p, wb_pkg::OP_MOVEI_L, k[0], k);
			end
			want = 4'b1111;
			issue_all();
		end
		drain();

		// All pipes bursting so the FIFOs stay busy and the flags rise
		track_occ <= 1'b1;
		foreach (sent[p]) sent[p] = 0;
		while (sent[0] + sent[1] + sent[2] + sent[3] < NP * BURST_LEN) begin
			for (int p = 0; p < NP; p++) begin
				want[p] = (sent[p] < BURST_LEN);
				rnd = $random(seed);
				stage[p] = make_result(p, wb_pkg::opcode_t'({1'b0, rnd[3:0]}), 1'b1, sent[p]);
			end
			issue(taken);
			for (int p = 0; p < NP; p++) begin
				if (taken[p]) begin
					sent[p]++;
				end
			end
		end
		want = '0;
		drain();
		for (int p = 0; p < NP; p++) begin
			if (!flag_seen[p]) begin
				errors++;
				$display("Full flag of pipe %0d never rose during the burst", p);
			end
		end
		track_occ <= 1'b0;
		idle(2);
		finish_run();
	end

endmodule

// ==== flist.f ====
source/wb_pkg.sv
source/wb_request_fifo.sv
source/wb_rr_arbiter.sv
source/load_result_composer.sv
source/writeback_stage.sv
tests/clock_gen.sv
tests/writeback_tb.sv

// ==== Makefile ====
VERILATOR  ?= verilator
TOP        = writeback_tb
FLIST      = flist.f
OBJ_DIR    = obj_dir
FLAGS      = --binary --timing --assert -Wno-fatal --top-module $(TOP) --Mdir $(OBJ_DIR)
LINT_FLAGS = --lint-only --timing --top-module $(TOP)

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(FLAGS) -f $(FLIST)

# Pass or fail comes from the simulation output alone
run: build
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "TESTS PASSED"

lint:
	$(VERILATOR) $(LINT_FLAGS) -f $(FLIST)

clean:
	rm -rf $(OBJ_DIR)
